// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bank_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/bank_checker.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_checker import bank_pkg::*; (
    input logic                            clk,
    input logic                            reset,
    // One bit per queue: request, fill, response
    input logic [2:0]                      push,
    input logic [2:0]                      pop,
    input logic [2:0]                      full,
    input logic [2:0]                      empty,
    input logic                            core_rsp_valid,
    input logic                            core_rsp_ready,
    input core_rsp_t                       core_rsp,
    input logic                            dram_fill_req_valid,
    input logic                            dram_fill_req_ready,
    input logic [`BANK_LINE_ADDR_BITS-1:0] dram_fill_req_addr
);

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        (push & full) == 3'b000)
        else $error("queue pushed while full");

    no_underflow: assert property (@(posedge clk) disable iff (reset)
        (pop & empty) == 3'b000)
        else $error("queue popped while empty");

    rsp_stable: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core response changed before it was taken");

    fill_req_stable: assert property (@(posedge clk) disable iff (reset)
        dram_fill_req_valid && !dram_fill_req_ready
        |=> dram_fill_req_valid && $stable(dram_fill_req_addr))
        else $error("fill request dropped or changed before it was taken");

endmodule

// File: dv/bank_tb.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_tb import bank_pkg::*; ();
    localparam int ROW_CYCLES = 200;
    localparam int M_THROTTLE = 1;
    localparam int M_BACKP    = 2;
    localparam int M_HOLD     = 4;
    localparam int M_MIX      = 8;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      core_req_valid = 1'b0;
    core_req_t core_req = '0;
    logic      core_req_ready;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      core_rsp_ready = 1'b0;
    logic      dram_fill_req_valid;
    logic [`BANK_LINE_ADDR_BITS-1:0] dram_fill_req_addr;
    logic      dram_fill_req_ready = 1'b0;
    logic      dram_fill_rsp_valid = 1'b0;
    fill_rsp_t dram_fill_rsp = '0;
    logic      dram_fill_rsp_ready;

    // Stimulus table
    string row_name[$];
    logic [15:0] row_addr[$];
    int row_count[$];
    int row_stride[$];
    int row_mode[$];
    int row_fills[$];
    bit table_ready = 1'b0;

    // Scoreboard, written only by the monitor
    logic [31:0] exp_data[64];
    logic [13:0] exp_line[64];
    bit outstanding[64];
    int outstanding_n = 0;
    logic [13:0] fill_log[$];
    int fill_taken_n = 0;

    string cur_name = "reset";
    int mode_now = 0;
    bit hold_rsp = 1'b0;
    bit saw_full = 1'b0;
    logic [5:0] next_tag = '0;
    logic [31:0] addr_rng = 32'd35;

    // DRAM model state
    logic [31:0] rng = 32'd35;
    int cycle = 0;
    int fill_next = 0;
    int fill_done_n = 0;
    logic [13:0] dram_line_q[$];
    int dram_due_q[$];

    bank_top DUT (.*);

    bind bank_top bank_checker checker_inst (
        .clk(clk), .reset(reset),
        .push({reqq_push, fillq_push, rsp_push}), .pop({reqq_pop, fillq_pop, rspq_pop}),
        .full({reqq_full, fillq_full, rspq_full}),
        .empty({reqq_empty, fillq_empty, rspq_empty}),
        .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready),
        .core_rsp(core_rsp), .dram_fill_req_valid(dram_fill_req_valid),
        .dram_fill_req_ready(dram_fill_req_ready), .dram_fill_req_addr(dram_fill_req_addr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Fixed data pattern of a word address
    function automatic logic [31:0] dram_word(input logic [15:0] addr);
        logic [31:0] x;
        x = {addr, ~addr};
        return (x * 32'h9e3779b1) ^ {addr[7:0], addr[15:8], addr};
    endfunction

    function automatic bit line_wanted(input logic [13:0] line);
        for (int t = 0; t < 64; t++) begin
            if (outstanding[t] && exp_line[t] == line) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic abort_run(input string what);
        $display("Error: %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("Error: test %s expected %0h actual %0h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic add_row(input string name, input logic [15:0] addr, input int count,
                           input int stride, input int mode, input int fills);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_count.push_back(count);
        row_stride.push_back(stride);
        row_mode.push_back(mode);
        row_fills.push_back(fills);
    endtask

    // Called just after a rising edge, returns just after the edge that took it
    task automatic send_read(input logic [15:0] addr);
        core_req_valid = 1'b1;
        core_req.addr  = addr;
        core_req.tag   = next_tag;
        next_tag       = next_tag + 1'b1;
        @(negedge clk);
        while (!core_req_ready) begin
            saw_full = 1'b1;
            hold_rsp = 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
    endtask

    // Handshakes seen mid cycle complete on the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (core_req_valid && core_req_ready) begin
                assert (!outstanding[core_req.tag])
                    else abort_run($sformatf("tag %0d reused while outstanding", core_req.tag));
                exp_data[core_req.tag] = dram_word(core_req.addr);
                exp_line[core_req.tag] = core_req.addr[15:2];
                outstanding[core_req.tag] = 1'b1;
                outstanding_n++;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                assert (outstanding[core_rsp.tag])
                    else abort_run($sformatf("response for tag %0d nobody waits for",
                                             core_rsp.tag));
                assert (core_rsp.data == exp_data[core_rsp.tag])
                    else flag_mismatch(cur_name, exp_data[core_rsp.tag], core_rsp.data);
                outstanding[core_rsp.tag] = 1'b0;
                outstanding_n--;
            end
            if (dram_fill_req_valid && dram_fill_req_ready) begin
                assert (line_wanted(dram_fill_req_addr))
                    else abort_run($sformatf("fill request for line %0h that no read missed",
                                             dram_fill_req_addr));
                fill_log.push_back(dram_fill_req_addr);
            end
            if (dram_fill_rsp_valid && dram_fill_rsp_ready) begin
                fill_taken_n++;
            end
        end
    end

    // Ready throttling and in-order DRAM fill responses
    always @(posedge clk) begin
        #1;
        cycle++;
        rng = xorshift(rng);
        dram_fill_req_ready = ((mode_now & M_THROTTLE) != 0) ? rng[4] : 1'b1;
        if (hold_rsp) begin
            core_rsp_ready = 1'b0;
        end else if ((mode_now & M_BACKP) != 0) begin
            core_rsp_ready = rng[11];
        end else begin
            core_rsp_ready = 1'b1;
        end
        while (fill_next < fill_log.size()) begin
            dram_line_q.push_back(fill_log[fill_next]);
            dram_due_q.push_back(cycle + 3 + int'(rng[20:18]));
            fill_next++;
        end
        if (fill_done_n != fill_taken_n) begin
            dram_fill_rsp_valid = 1'b0;
            fill_done_n = fill_taken_n;
        end
        if (!dram_fill_rsp_valid && dram_line_q.size() > 0 && dram_due_q[0] <= cycle) begin
            void'(dram_due_q.pop_front());
            dram_fill_rsp.line_addr = dram_line_q.pop_front();
            for (int w = 0; w < 4; w++) begin
                dram_fill_rsp.data[w] = dram_word({dram_fill_rsp.line_addr, 2'(w)});
            end
            dram_fill_rsp_valid = 1'b1;
        end
    end

    initial begin
        wait (table_ready);
        repeat (ROW_CYCLES * (row_name.size() + 1)) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [15:0] addr_list[$];
        int fills_before;
        int fills_seen;
        add_row("cold", 16'h0104, 1, 0, 0, 1);
        add_row("warm", 16'h0106, 1, 0, 0, 0);
        add_row("burst", 16'h0200, 4, 1, 0, 1);
        add_row("alias_a", 16'h0300, 1, 0, 0, 1);
        add_row("alias_b", 16'h0340, 1, 0, 0, 1);
        add_row("alias_a2", 16'h0301, 1, 0, 0, 1);
        add_row("alias_b2", 16'h0342, 1, 0, 0, 1);
        add_row("mixed", 16'h1000, 32, 0, M_THROTTLE | M_BACKP | M_MIX, -1);
        add_row("hold", 16'h0500, 24, 1, M_HOLD, -1);
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (20) begin
            @(negedge clk);
            assert (!core_rsp_valid && !dram_fill_req_valid && core_req_ready
                    && dram_fill_rsp_ready)
                else abort_run("DUT not idle after reset");
        end
        for (int r = 0; r < row_name.size(); r++) begin
            @(negedge clk);
            cur_name = row_name[r];
            mode_now = row_mode[r];
            hold_rsp = (row_mode[r] & M_HOLD) != 0;
            saw_full = 1'b0;
            fills_before = fill_log.size();
            addr_list.delete();
            for (int i = 0; i < row_count[r]; i++) begin
                if ((row_mode[r] & M_MIX) != 0) begin
                    addr_rng = xorshift(addr_rng);
                    addr_list.push_back(row_addr[r] + {8'h00, addr_rng[7:0]});
                end else begin
                    addr_list.push_back(row_addr[r] + 16'(i * row_stride[r]));
                end
            end
            @(posedge clk);
            #1;
            foreach (addr_list[i]) begin
                send_read(addr_list[i]);
            end
            @(negedge clk);
            hold_rsp = 1'b0;
            assert ((row_mode[r] & M_HOLD) == 0 || saw_full)
                else abort_run("core_req_ready never dropped while responses were held");
            while (outstanding_n != 0) begin
                @(negedge clk);
            end
            fills_seen = fill_log.size() - fills_before;
            assert (row_fills[r] < 0 || fills_seen == row_fills[r])
                else flag_mismatch(cur_name, row_fills[r], fills_seen);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog/bank_fifo.sv
`timescale 1ns/1ps

module bank_fifo #(
    parameter int DATA_BITS = 8,
    parameter int DEPTH     = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic [DATA_BITS-1:0] data_in,
    input  logic                 pop,
    output logic [DATA_BITS-1:0] data_out,
    output logic                 empty,
    output logic                 full
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [CNT_BITS-1:0]  count;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_BITS'(DEPTH));

endmodule

// File: verilog/bank_miss_resrv.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_miss_resrv import bank_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            miss_add,
    input  pipe_rsp_t                       st2,
    input  pipe_req_t                       st1,
    input  logic                            st0_fill_valid,
    input  logic [`BANK_LINE_ADDR_BITS-1:0] st0_fill_addr,
    input  logic                            replay_pop,
    output logic                            pending,
    output logic                            full,
    output logic                            stop,
    output logic                            replay_valid,
    output mrvq_entry_t                     replay_entry
);
    localparam int DEPTH    = `BANK_MRVQ_DEPTH;
    localparam int IDX_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]    entry_valid;
    logic [DEPTH-1:0]    entry_ready;
    mrvq_entry_t         entries [DEPTH];

    logic [IDX_BITS-1:0] free_idx;
    logic [IDX_BITS-1:0] replay_idx;
    logic [CNT_BITS-1:0] free_count;
    logic [DEPTH-1:0]    pend_match;
    logic                fill_st1;
    logic                init_ready;

    assign fill_st1 = st1.valid && st1.is_fill;

    // Descending scan leaves the lowest index selected
    always_comb begin
        free_idx     = '0;
        replay_idx   = '0;
        replay_valid = 1'b0;
        free_count   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx   = IDX_BITS'(i);
                free_count = free_count + 1'b1;
            end
            if (entry_valid[i] && entry_ready[i]) begin
                replay_idx   = IDX_BITS'(i);
                replay_valid = 1'b1;
            end
            pend_match[i] = entry_valid[i] && !entry_ready[i]
                            && (entries[i].line_addr == st2.line_addr);
        end
    end

    assign pending      = |pend_match;
    assign full         = &entry_valid;
    assign stop         = (free_count < CNT_BITS'(`BANK_MRVQ_MARGIN));
    assign replay_entry = entries[replay_idx];

    // Line already being filled, so no broadcast will come for it
    assign init_ready = (fill_st1 && (st1.line_addr == st2.line_addr))
                        || (st0_fill_valid && (st0_fill_addr == st2.line_addr));

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            entry_ready <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (fill_st1 && entry_valid[i] && (entries[i].line_addr == st1.line_addr)) begin
                    entry_ready[i] <= 1'b1;
                end
            end
            if (replay_pop) begin
                entry_valid[replay_idx] <= 1'b0;
                entry_ready[replay_idx] <= 1'b0;
            end
            if (miss_add) begin
                entry_valid[free_idx] <= 1'b1;
                entry_ready[free_idx] <= init_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_add) begin
            entries[free_idx] <= '{line_addr: st2.line_addr, wsel: st2.wsel, tag: st2.tag};
        end
    end

endmodule

// File: verilog/bank_params.svh
`ifndef BANK_PARAMS_SVH
`define BANK_PARAMS_SVH

// Line geometry
`define BANK_WORD_BITS       32
`define BANK_WORDS_PER_LINE  4
`define BANK_WSEL_BITS       2
`define BANK_LINES           16
`define BANK_INDEX_BITS      4

// Address split: tag | index | word select
`define BANK_ADDR_BITS       16
`define BANK_LINE_ADDR_BITS  14
`define BANK_TAG_BITS        10
`define BANK_REQ_TAG_BITS    6

// Queue and table sizes
`define BANK_REQQ_DEPTH      4
`define BANK_FILLQ_DEPTH     2
`define BANK_RSPQ_DEPTH      4
`define BANK_MRVQ_DEPTH      8
// Two stages in flight plus one spare
`define BANK_MRVQ_MARGIN     3

`endif

// File: verilog/bank_pkg.sv
`include "bank_params.svh"

package bank_pkg;

    typedef logic [`BANK_WORDS_PER_LINE-1:0][`BANK_WORD_BITS-1:0] line_data_t;

    typedef struct packed {
        logic [`BANK_ADDR_BITS-1:0]    addr;
        logic [`BANK_REQ_TAG_BITS-1:0] tag;
    } core_req_t;

    typedef struct packed {
        logic [`BANK_REQ_TAG_BITS-1:0] tag;
        logic [`BANK_WORD_BITS-1:0]    data;
    } core_rsp_t;

    typedef struct packed {
        logic [`BANK_LINE_ADDR_BITS-1:0] line_addr;
        line_data_t                      data;
    } fill_rsp_t;

    // Stage 0 to 1
    typedef struct packed {
        logic                            valid;
        logic                            is_fill;
        logic                            is_replay;
        logic [`BANK_LINE_ADDR_BITS-1:0] line_addr;
        logic [`BANK_WSEL_BITS-1:0]      wsel;
        logic [`BANK_REQ_TAG_BITS-1:0]   tag;
        line_data_t                      line;
    } pipe_req_t;

    // Stage 1 to 2
    typedef struct packed {
        logic                            valid;
        logic                            is_fill;
        logic                            is_replay;
        logic                            hit;
        logic [`BANK_LINE_ADDR_BITS-1:0] line_addr;
        logic [`BANK_WSEL_BITS-1:0]      wsel;
        logic [`BANK_REQ_TAG_BITS-1:0]   tag;
        logic [`BANK_WORD_BITS-1:0]      word;
    } pipe_rsp_t;

    typedef struct packed {
        logic [`BANK_LINE_ADDR_BITS-1:0] line_addr;
        logic [`BANK_WSEL_BITS-1:0]      wsel;
        logic [`BANK_REQ_TAG_BITS-1:0]   tag;
    } mrvq_entry_t;

endpackage

// File: verilog/bank_retire.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_retire import bank_pkg::*; (
    input  pipe_rsp_t                       st2,
    input  logic                            rspq_full,
    input  logic                            pending,
    input  logic                            mrvq_full,
    input  logic                            dram_fill_req_ready,
    output logic                            rsp_push,
    output core_rsp_t                       rsp,
    output logic                            miss_add,
    output logic                            dram_fill_req_valid,
    output logic [`BANK_LINE_ADDR_BITS-1:0] dram_fill_req_addr,
    output logic                            stall
);
    logic hit_req;
    logic miss_req;
    logic first_miss;
    logic rsp_stall;
    logic fill_stall;
    logic mrvq_stall;

    assign hit_req    = st2.valid && !st2.is_fill && st2.hit;
    assign miss_req   = st2.valid && !st2.is_fill && !st2.hit;
    // Secondary misses ride on the fill already requested
    assign first_miss = miss_req && !pending;

    assign rsp_stall  = hit_req && rspq_full;
    assign fill_stall = first_miss && !dram_fill_req_ready;
    assign mrvq_stall = miss_req && mrvq_full;
    assign stall      = rsp_stall || fill_stall || mrvq_stall;

    assign rsp_push = hit_req && !stall;
    assign rsp.tag  = st2.tag;
    assign rsp.data = st2.word;

    assign miss_add = miss_req && !stall;

    // Not gated by ready, so it stays up until taken
    assign dram_fill_req_valid = first_miss && !mrvq_stall;
    assign dram_fill_req_addr  = st2.line_addr;

endmodule

// File: verilog/bank_select.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_select import bank_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        replay_valid,
    input  mrvq_entry_t replay_entry,
    input  logic        fill_valid,
    input  fill_rsp_t   fill,
    input  logic        core_valid,
    input  core_req_t   core,
    input  logic        stop,
    output logic        replay_pop,
    output logic        fill_pop,
    output logic        core_pop,
    output pipe_req_t   st1
);
    pipe_req_t st0;
    logic      fill_in_st1;

    assign fill_in_st1 = st1.valid && st1.is_fill;

    // Replay first, then fill, then core
    assign replay_pop = replay_valid && !stall;
    assign fill_pop   = fill_valid && !replay_pop && !stall;
    assign core_pop   = core_valid && !replay_pop && !fill_pop && !stall
                        && !stop && !fill_in_st1;

    always_comb begin
        st0 = '0;
        if (replay_pop) begin
            st0.valid     = 1'b1;
            st0.is_replay = 1'b1;
            st0.line_addr = replay_entry.line_addr;
            st0.wsel      = replay_entry.wsel;
            st0.tag       = replay_entry.tag;
        end else if (fill_pop) begin
            st0.valid     = 1'b1;
            st0.is_fill   = 1'b1;
            st0.line_addr = fill.line_addr;
            st0.line      = fill.data;
        end else if (core_pop) begin
            st0.valid     = 1'b1;
            st0.line_addr = core.addr[`BANK_ADDR_BITS-1:`BANK_WSEL_BITS];
            st0.wsel      = core.addr[`BANK_WSEL_BITS-1:0];
            st0.tag       = core.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1.valid     <= 1'b0;
            st1.is_fill   <= 1'b0;
            st1.is_replay <= 1'b0;
        end else if (!stall) begin
            st1 <= st0;
        end
    end

endmodule

// File: verilog/bank_tag_data.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_tag_data import bank_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  pipe_req_t st1,
    output pipe_rsp_t st2
);
    logic [`BANK_LINES-1:0]     line_valid;
    logic [`BANK_TAG_BITS-1:0]  tag_mem [`BANK_LINES];
    line_data_t                 data_mem [`BANK_LINES];

    logic [`BANK_INDEX_BITS-1:0] index;
    logic [`BANK_TAG_BITS-1:0]   tag;
    logic                        write_fill;
    pipe_rsp_t                   st2_next;

    assign index      = st1.line_addr[`BANK_INDEX_BITS-1:0];
    assign tag        = st1.line_addr[`BANK_LINE_ADDR_BITS-1:`BANK_INDEX_BITS];
    assign write_fill = st1.valid && st1.is_fill;

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_fill) begin
            line_valid[index] <= 1'b1;
        end
    end

    // Fill replaces the whole line and its tag
    always_ff @(posedge clk) begin
        if (write_fill) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= st1.line;
        end
    end

    always_comb begin
        st2_next           = '0;
        st2_next.valid     = st1.valid;
        st2_next.is_fill   = st1.is_fill;
        st2_next.is_replay = st1.is_replay;
        st2_next.hit       = !st1.is_fill && line_valid[index] && (tag_mem[index] == tag);
        st2_next.line_addr = st1.line_addr;
        st2_next.wsel      = st1.wsel;
        st2_next.tag       = st1.tag;
        st2_next.word      = data_mem[index][st1.wsel];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st2.valid     <= 1'b0;
            st2.is_fill   <= 1'b0;
            st2.is_replay <= 1'b0;
            st2.hit       <= 1'b0;
        end else if (!stall) begin
            st2 <= st2_next;
        end
    end

endmodule

// File: verilog/bank_top.sv
`timescale 1ns/1ps
`include "bank_params.svh"

module bank_top import bank_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            core_req_valid,
    input  core_req_t                       core_req,
    output logic                            core_req_ready,
    output logic                            core_rsp_valid,
    output core_rsp_t                       core_rsp,
    input  logic                            core_rsp_ready,
    output logic                            dram_fill_req_valid,
    output logic [`BANK_LINE_ADDR_BITS-1:0] dram_fill_req_addr,
    input  logic                            dram_fill_req_ready,
    input  logic                            dram_fill_rsp_valid,
    input  fill_rsp_t                       dram_fill_rsp,
    output logic                            dram_fill_rsp_ready
);
    logic        reqq_push, reqq_pop, reqq_empty, reqq_full;
    core_req_t   reqq_head;
    logic        fillq_push, fillq_pop, fillq_empty, fillq_full;
    fill_rsp_t   fillq_head;
    logic        rsp_push, rspq_pop, rspq_empty, rspq_full;
    core_rsp_t   rsp;
    logic        replay_valid, replay_pop, pending, mrvq_full, stop;
    mrvq_entry_t replay_entry;
    logic        stall, miss_add;
    pipe_req_t   st1;
    pipe_rsp_t   st2;

    assign core_req_ready      = !reqq_full;
    assign reqq_push           = core_req_valid && core_req_ready;
    assign dram_fill_rsp_ready = !fillq_full;
    assign fillq_push          = dram_fill_rsp_valid && dram_fill_rsp_ready;
    assign core_rsp_valid      = !rspq_empty;
    assign rspq_pop            = core_rsp_valid && core_rsp_ready;

    bank_fifo #(.DATA_BITS($bits(core_req_t)), .DEPTH(`BANK_REQQ_DEPTH)) req_queue (
        .clk(clk), .reset(reset), .push(reqq_push), .data_in(core_req),
        .pop(reqq_pop), .data_out(reqq_head), .empty(reqq_empty), .full(reqq_full)
    );

    bank_fifo #(.DATA_BITS($bits(fill_rsp_t)), .DEPTH(`BANK_FILLQ_DEPTH)) fill_queue (
        .clk(clk), .reset(reset), .push(fillq_push), .data_in(dram_fill_rsp),
        .pop(fillq_pop), .data_out(fillq_head), .empty(fillq_empty), .full(fillq_full)
    );

    bank_fifo #(.DATA_BITS($bits(core_rsp_t)), .DEPTH(`BANK_RSPQ_DEPTH)) rsp_queue (
        .clk(clk), .reset(reset), .push(rsp_push), .data_in(rsp),
        .pop(rspq_pop), .data_out(core_rsp), .empty(rspq_empty), .full(rspq_full)
    );

    bank_select select (
        .clk(clk), .reset(reset), .stall(stall),
        .replay_valid(replay_valid), .replay_entry(replay_entry),
        .fill_valid(!fillq_empty), .fill(fillq_head),
        .core_valid(!reqq_empty), .core(reqq_head), .stop(stop),
        .replay_pop(replay_pop), .fill_pop(fillq_pop), .core_pop(reqq_pop), .st1(st1)
    );

    bank_tag_data tag_data (
        .clk(clk), .reset(reset), .stall(stall), .st1(st1), .st2(st2)
    );

    bank_miss_resrv miss_resrv (
        .clk(clk), .reset(reset), .miss_add(miss_add), .st2(st2), .st1(st1),
        .st0_fill_valid(fillq_pop), .st0_fill_addr(fillq_head.line_addr),
        .replay_pop(replay_pop), .pending(pending), .full(mrvq_full), .stop(stop),
        .replay_valid(replay_valid), .replay_entry(replay_entry)
    );

    bank_retire retire (
        .st2(st2), .rspq_full(rspq_full), .pending(pending), .mrvq_full(mrvq_full),
        .dram_fill_req_ready(dram_fill_req_ready), .rsp_push(rsp_push), .rsp(rsp),
        .miss_add(miss_add), .dram_fill_req_valid(dram_fill_req_valid),
        .dram_fill_req_addr(dram_fill_req_addr), .stall(stall)
    );

endmodule

// File: vlog.f
+incdir+verilog
verilog/bank_pkg.sv
verilog/bank_fifo.sv
verilog/bank_select.sv
verilog/bank_tag_data.sv
verilog/bank_miss_resrv.sv
verilog/bank_retire.sv
verilog/bank_top.sv
dv/bank_checker.sv
dv/bank_tb.sv
